// File: rvseed_top.f
hw/rvseed_pkg.sv
hw/rvseed_fetch.sv
hw/rvseed_decoder.sv
hw/rvseed_imm_gen.sv
hw/rvseed_alu.sv
hw/rvseed_reg_file.sv
hw/rvseed_top.sv
verification/rvseed_asserts.sv
verification/rvseed_tb.sv

// File: Bender.yml
package:
  name: rvseed

sources:
  - hw/rvseed_pkg.sv
  - hw/rvseed_fetch.sv
  - hw/rvseed_decoder.sv
  - hw/rvseed_imm_gen.sv
  - hw/rvseed_alu.sv
  - hw/rvseed_reg_file.sv
  - hw/rvseed_top.sv
  - target: simulation
    files:
      - verification/rvseed_asserts.sv
      - verification/rvseed_tb.sv

// File: verification/rvseed_tb.sv
// rvseed_tb: clock, reset, random programs, wait-state instruction memory, reference model, checks
`default_nettype none

module rvseed_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import rvseed_pkg::*;

    localparam int CLK_PERIOD  = 20;
    localparam int PROGRAMS    = 4;
    localparam int PROG_LEN    = 64;   // random body, terminator at this index
    localparam int MEM_WORDS   = 1024;
    localparam int HALT_WATCH  = 10;
    localparam int CYCLE_LIMIT = PROGRAMS * (PROG_LEN + 1) * 6 + 200;

    logic                  clk;
    logic                  rst_n;
    logic [XLEN-1:0]       ibus_adr;
    logic [XLEN-1:0]       ibus_dat;
    logic                  ibus_cyc;
    logic                  ibus_stb;
    logic                  ibus_ack;
    logic                  commit_valid;
    logic [XLEN-1:0]       commit_pc;
    logic                  commit_wen;
    logic [REG_ADDR_W-1:0] commit_rd;
    logic [XLEN-1:0]       commit_data;
    logic                  halted;
    logic                  illegal;

    logic [31:0] mem [0:MEM_WORDS-1];
    int          wait_tab [0:127];      // wait cycles per fetch, drawn with the program
    int          waited;
    int          fetch_cnt;
    int          cycles = 0;
    int          errors = 0;
    int          total_retired = 0;

    // reference model state and the outcome of its last step
    logic [XLEN-1:0] m_pc;
    logic [XLEN-1:0] m_regs [0:31];
    logic            e_halt;
    logic            e_writes;
    logic            e_wen;
    logic [XLEN-1:0] e_data;

    rvseed_top #(
        .RESET_PC ( '0 )
    ) dut (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .ibus_adr     ( ibus_adr     ),
        .ibus_dat     ( ibus_dat     ),
        .ibus_cyc     ( ibus_cyc     ),
        .ibus_stb     ( ibus_stb     ),
        .ibus_ack     ( ibus_ack     ),
        .commit_valid ( commit_valid ),
        .commit_pc    ( commit_pc    ),
        .commit_wen   ( commit_wen   ),
        .commit_rd    ( commit_rd    ),
        .commit_data  ( commit_data  ),
        .halted       ( halted       ),
        .illegal      ( illegal      )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // registered ack after a random number of wait cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            ibus_ack  <= 1'b0;
            waited    <= 0;
            fetch_cnt <= 0;
        end else if (ibus_cyc && ibus_stb && !ibus_ack) begin
            if (waited >= wait_tab[fetch_cnt[6:0]]) begin
                ibus_ack  <= 1'b1;
                ibus_dat  <= mem[ibus_adr[11:2]];
                waited    <= 0;
                fetch_cnt <= fetch_cnt + 1;
            end else begin
                waited <= waited + 1;
            end
        end else begin
            ibus_ack <= 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: no end of test after %0d clock cycles", CYCLE_LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %0t ns: %s expected 0x%08h, got 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0];
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    // one instruction through the model, updates m_pc and m_regs
    task automatic model_exec(input logic [31:0] inst);
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_u;
        logic [31:0] next;
        f3     = inst[14:12];
        rd     = inst[11:7];
        a      = m_regs[inst[19:15]];
        b      = m_regs[inst[24:20]];
        imm_i  = {{20{inst[31]}}, inst[31:20]};
        imm_u  = {inst[31:12], 12'b0};
        next   = m_pc + 32'd4;
        e_halt = 1'b0;
        e_writes = 1'b1;
        e_data = '0;
        case (inst[6:0])
            7'h33: e_data = alu_ref(f3, inst[30], a, b);
            7'h13: e_data = alu_ref(f3, (f3 == 3'd5) && inst[30], a, imm_i);
            7'h37: e_data = imm_u;
            7'h17: e_data = m_pc + imm_u;
            7'h6f: begin
                e_data = m_pc + 32'd4;
                next   = m_pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            7'h67: begin
                e_data = m_pc + 32'd4;
                next   = (a + imm_i) & ~32'd1;
            end
            7'h63: begin
                e_writes = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    next = m_pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                end
            end
            default: begin   // ebreak or unknown opcode
                e_writes = 1'b0;
                e_halt   = 1'b1;
            end
        endcase
        e_wen = e_writes && (rd != 5'd0);
        if (e_wen) begin
            m_regs[rd] = e_data;
        end
        m_pc = next;
    endtask

    task automatic gen_program(input bit end_illegal);
        logic [31:0] w;
        logic [20:0] off;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          kind;
        int          tgt;
        for (int k = 0; k < MEM_WORDS; k++) begin
            mem[k] = {k[24:0], 7'h00};   // opcode 0 traps if ever fetched
        end
        for (int k = 0; k < 128; k++) begin
            wait_tab[k] = $urandom_range(3);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            w    = $urandom;
            kind = $urandom_range(9);
            rd   = $urandom_range(15);  // small register range, more reuse
            rs1  = $urandom_range(15);
            rs2  = $urandom_range(15);
            f3   = $urandom_range(7);
            f7   = w[30] ? 7'h20 : 7'h00;
            tgt  = $urandom_range(PROG_LEN, i + 1);   // forward only
            off  = 21'((tgt - i) * 4);
            case (kind)
                0, 1, 2: begin
                    if (f3 != 3'd0 && f3 != 3'd5) f7 = 7'h00;
                    w = {f7, rs2, rs1, f3, rd, 7'h33};
                end
                3, 4: begin
                    if (f3 == 3'd1) w = {7'h00, w[24:20], rs1, f3, rd, 7'h13};
                    else if (f3 == 3'd5) w = {f7, w[24:20], rs1, f3, rd, 7'h13};
                    else w = {w[31:20], rs1, f3, rd, 7'h13};
                end
                5: w = {w[31:12], rd, 7'h37};
                6: w = {w[31:12], rd, 7'h17};
                7: w = {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
                8: w = {12'(tgt * 4), 5'd0, 3'd0, rd, 7'h67};   // absolute, pc starts at 0
                default: begin
                    f3 = $urandom_range(5);
                    if (f3 > 3'd1) f3 = f3 + 3'd2;
                    w = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
                end
            endcase
            mem[i] = w;
        end
        w = $urandom;
        mem[PROG_LEN] = end_illegal ? {w[31:7], 7'h0b} : 32'h0010_0073;
        mem[PROG_LEN + 1] = 32'h0010_0093;   // addi x1, x0, 1 never reached
    endtask

    task automatic reset_core();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_program(input bit expect_illegal);
        logic [31:0] exp_pc;
        logic [31:0] exp_inst;
        bit          pend;
        bit          done;
        bit          cyc_seen;
        int          n_fetch;
        int          n_retire;
        pend     = 1'b0;
        done     = 1'b0;
        cyc_seen = 1'b0;
        n_fetch  = 0;
        n_retire = 0;
        reset_core();
        m_pc = '0;
        for (int r = 0; r < 32; r++) begin
            m_regs[r] = '0;
        end
        @(negedge clk);
        check_value("ibus_cyc", ibus_cyc, 1'b0);
        check_value("ibus_stb", ibus_stb, 1'b0);
        check_value("commit_valid", commit_valid, 1'b0);
        check_value("halted", halted, 1'b0);
        check_value("illegal", illegal, 1'b0);
        check_value("ibus_adr", ibus_adr, '0);
        while (!done) begin
            @(negedge clk);
            if (pend) begin   // exec cycle, one after ack
                pend     = 1'b0;
                exp_pc   = m_pc;
                exp_inst = mem[m_pc[11:2]];
                model_exec(exp_inst);
                if (e_halt) begin
                    check_value("commit_valid", commit_valid, 1'b0);
                    done = 1'b1;
                end else begin
                    n_retire++;
                    check_value("commit_valid", commit_valid, 1'b1);
                    check_value("commit_pc", commit_pc, exp_pc);
                    check_value("commit_wen", commit_wen, e_wen);
                    if (e_writes) begin
                        check_value("commit_rd", commit_rd, exp_inst[11:7]);
                        check_value("commit_data", commit_data, e_data);
                    end
                end
            end else begin
                check_value("commit_valid", commit_valid, 1'b0);
            end
            if (ibus_cyc && !cyc_seen) begin
                n_fetch++;   // a new bus cycle opens
            end
            cyc_seen = ibus_cyc;
            if (ibus_cyc && ibus_stb && ibus_ack) begin
                check_value("ibus_adr", ibus_adr, m_pc);
                pend = 1'b1;
            end
        end
        check_value("fetch_count", n_fetch, n_retire + 1);  // terminator fetched, not retired
        repeat (HALT_WATCH) begin
            @(negedge clk);
            check_value("halted", halted, 1'b1);
            check_value("illegal", illegal, expect_illegal);
            check_value("commit_valid", commit_valid, 1'b0);
            check_value("ibus_cyc", ibus_cyc, 1'b0);
        end
        total_retired += n_retire;
    endtask

    initial begin
        void'($urandom(41511));
        clk      = 1'b0;
        rst_n    = 1'b0;
        ibus_ack = 1'b0;
        ibus_dat = '0;
        for (int p = 0; p < PROGRAMS; p++) begin
            gen_program(p == PROGRAMS - 1);   // last one ends on an unknown opcode
            run_program(p == PROGRAMS - 1);
        end
        $display("summary: %0d programs, %0d instructions retired, %0d errors",
                 PROGRAMS, total_retired, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/rvseed_asserts.sv
// rvseed_asserts: Wishbone fetch and retire protocol properties, bound into rvseed_top
`default_nettype none

module rvseed_asserts (
    input logic                        clk,
    input logic                        rst_n,
    input logic [rvseed_pkg::XLEN-1:0] ibus_adr,
    input logic                        ibus_cyc,
    input logic                        ibus_stb,
    input logic                        ibus_ack,
    input logic                        commit_valid,
    input logic                        halted
);
    timeunit 1ns;
    timeprecision 100ps;

    a_stb_in_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) ibus_stb |-> ibus_cyc
    ) else $error("ibus_stb high outside a bus cycle");

    // request and address held until the slave acks
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        (ibus_stb && !ibus_ack) |=> (ibus_stb && $stable(ibus_adr))
    ) else $error("ibus_stb or ibus_adr changed before ibus_ack");

    a_retire_off_bus: assert property (
        @(posedge clk) disable iff (!rst_n) commit_valid |-> !ibus_cyc
    ) else $error("commit_valid together with ibus_cyc");

    a_quiet_halt: assert property (
        @(posedge clk) disable iff (!rst_n) halted |-> !ibus_cyc
    ) else $error("bus cycle started after halt");

endmodule

bind rvseed_top rvseed_asserts u_asserts (
    .clk          ( clk          ),
    .rst_n        ( rst_n        ),
    .ibus_adr     ( ibus_adr     ),
    .ibus_cyc     ( ibus_cyc     ),
    .ibus_stb     ( ibus_stb     ),
    .ibus_ack     ( ibus_ack     ),
    .commit_valid ( commit_valid ),
    .halted       ( halted       )
);

`default_nettype wire

// File: hw/rvseed_top.sv
// rvseed_top: core top level tying fetch, decoder, immediates, ALU and register file together
`default_nettype none

module rvseed_top #(
    parameter logic [rvseed_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    output logic [rvseed_pkg::XLEN-1:0]       ibus_adr,
    input  logic [rvseed_pkg::XLEN-1:0]       ibus_dat,
    output logic                              ibus_cyc,
    output logic                              ibus_stb,
    input  logic                              ibus_ack,
    output logic                              commit_valid,
    output logic [rvseed_pkg::XLEN-1:0]       commit_pc,
    output logic                              commit_wen,
    output logic [rvseed_pkg::REG_ADDR_W-1:0] commit_rd,
    output logic [rvseed_pkg::XLEN-1:0]       commit_data,
    output logic                              halted,
    output logic                              illegal
);
    import rvseed_pkg::*;

    logic [ILEN-1:0]       inst;
    logic [XLEN-1:0]       pc;
    logic                  exec;        // one cycle per fetched instruction
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic                  reg_wen;
    alu_op_e               alu_op;
    cmp_op_e               cmp_op;
    src_a_e                src_a;
    src_b_e                src_b;
    imm_sel_e              imm_sel;
    logic                  branch;
    logic                  jump;
    logic                  jalr;
    logic                  ebreak;
    logic                  illegal_op;
    logic [XLEN-1:0]       imm;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [XLEN-1:0]       result;      // also the write-back value
    logic                  cond_true;

    rvseed_fetch #(
        .RESET_PC ( RESET_PC )
    ) u_fetch (.*);

    rvseed_decoder u_decoder (.*);

    rvseed_imm_gen u_imm_gen (.*);

    rvseed_alu u_alu (.*);

    rvseed_reg_file u_reg_file (
        .clk    ( clk      ),
        .rst_n  ( rst_n    ),
        .exec   ( exec     ),
        .wen    ( reg_wen  ),
        .waddr  ( rd       ),
        .wdata  ( result   ),
        .raddr1 ( rs1      ),
        .raddr2 ( rs2      ),
        .rdata1 ( rs1_data ),
        .rdata2 ( rs2_data )
    );

    // retire trace, sampled while commit_valid is high
    assign commit_pc   = pc;
    assign commit_wen  = reg_wen;
    assign commit_rd   = rd;
    assign commit_data = result;

endmodule

`default_nettype wire

// File: hw/rvseed_reg_file.sv
// rvseed_reg_file: x1..x31 with two read ports and one write port, x0 reads zero
`default_nettype none

module rvseed_reg_file (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              exec,
    input  logic                              wen,
    input  logic [rvseed_pkg::REG_ADDR_W-1:0] waddr,
    input  logic [rvseed_pkg::XLEN-1:0]       wdata,
    input  logic [rvseed_pkg::REG_ADDR_W-1:0] raddr1,
    input  logic [rvseed_pkg::REG_ADDR_W-1:0] raddr2,
    output logic [rvseed_pkg::XLEN-1:0]       rdata1,
    output logic [rvseed_pkg::XLEN-1:0]       rdata2
);
    import rvseed_pkg::*;

    logic [XLEN-1:0] regs [1:31];  // no storage for x0

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (exec && wen && (waddr != '0)) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hw/rvseed_alu.sv
// rvseed_alu: operand muxes, arithmetic and logic result, branch compare
`default_nettype none

module rvseed_alu (
    input  rvseed_pkg::alu_op_e         alu_op,
    input  rvseed_pkg::cmp_op_e         cmp_op,
    input  rvseed_pkg::src_a_e          src_a,
    input  rvseed_pkg::src_b_e          src_b,
    input  logic [rvseed_pkg::XLEN-1:0] rs1_data,
    input  logic [rvseed_pkg::XLEN-1:0] rs2_data,
    input  logic [rvseed_pkg::XLEN-1:0] imm,
    input  logic [rvseed_pkg::XLEN-1:0] pc,
    output logic [rvseed_pkg::XLEN-1:0] result,
    output logic                        cond_true
);
    import rvseed_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [4:0]      shamt;

    always_comb begin
        case (src_a)
            SRC_A_PC:   op_a = pc;
            SRC_A_ZERO: op_a = '0;
            default:    op_a = rs1_data;
        endcase
        case (src_b)
            SRC_B_RS2:  op_b = rs2_data;
            SRC_B_FOUR: op_b = XLEN'(4);
            default:    op_b = imm;
        endcase
    end

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_SUB:  result = op_a - op_b;
            ALU_SLL:  result = op_a << shamt;
            ALU_SLT:  result = XLEN'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = XLEN'(op_a < op_b);
            ALU_XOR:  result = op_a ^ op_b;
            ALU_SRL:  result = op_a >> shamt;
            ALU_SRA:  result = $signed(op_a) >>> shamt;
            ALU_OR:   result = op_a | op_b;
            ALU_AND:  result = op_a & op_b;
            default:  result = op_a + op_b;
        endcase
    end

    // compare always on the register operands, independent of the muxes
    always_comb begin
        case (cmp_op)
            CMP_NE:  cond_true = (rs1_data != rs2_data);
            CMP_LT:  cond_true = ($signed(rs1_data) < $signed(rs2_data));
            CMP_GE:  cond_true = ($signed(rs1_data) >= $signed(rs2_data));
            CMP_LTU: cond_true = (rs1_data < rs2_data);
            CMP_GEU: cond_true = (rs1_data >= rs2_data);
            default: cond_true = (rs1_data == rs2_data);
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rvseed_imm_gen.sv
// rvseed_imm_gen: sign-extended I, S, B, U and J immediates
`default_nettype none

module rvseed_imm_gen (
    input  logic [rvseed_pkg::ILEN-1:0] inst,
    input  rvseed_pkg::imm_sel_e        imm_sel,
    output logic [rvseed_pkg::XLEN-1:0] imm
);
    import rvseed_pkg::*;

    always_comb begin
        case (imm_sel)
            IMM_S:   imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            IMM_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {inst[31:12], 12'b0};
            IMM_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{21{inst[31]}}, inst[30:20]};  // I format
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rvseed_decoder.sv
// rvseed_decoder: opcode, funct3 and funct7 to register indices and datapath controls
`default_nettype none

module rvseed_decoder (
    input  logic [rvseed_pkg::ILEN-1:0]       inst,
    output logic [rvseed_pkg::REG_ADDR_W-1:0] rs1,
    output logic [rvseed_pkg::REG_ADDR_W-1:0] rs2,
    output logic [rvseed_pkg::REG_ADDR_W-1:0] rd,
    output logic                              reg_wen,
    output rvseed_pkg::alu_op_e               alu_op,
    output rvseed_pkg::cmp_op_e               cmp_op,
    output rvseed_pkg::src_a_e                src_a,
    output rvseed_pkg::src_b_e                src_b,
    output rvseed_pkg::imm_sel_e              imm_sel,
    output logic                              branch,
    output logic                              jump,
    output logic                              jalr,
    output logic                              ebreak,
    output logic                              illegal_op
);
    import rvseed_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       alt;          // sub or sra selected by funct7[5]
    logic       writes;
    alu_op_e    arith_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign rs1    = inst[19:15];
    assign rs2    = inst[24:20];
    assign rd     = inst[11:7];

    // addi never turns into sub, only srai uses the alt bit
    assign alt = funct7[5] & ((opcode == OPC_OP) | (funct3 == 3'b101));

    always_comb begin
        case (funct3)
            3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        writes     = 1'b0;
        alu_op     = ALU_ADD;
        cmp_op     = CMP_EQ;
        src_a      = SRC_A_RS1;
        src_b      = SRC_B_IMM;
        imm_sel    = IMM_I;
        branch     = 1'b0;
        jump       = 1'b0;
        jalr       = 1'b0;
        ebreak     = 1'b0;
        illegal_op = 1'b0;
        case (opcode)
            OPC_OP: begin
                writes     = 1'b1;
                src_b      = SRC_B_RS2;
                alu_op     = arith_op;
                illegal_op = !(funct7 == 7'h00 ||
                               (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                writes = 1'b1;
                alu_op = arith_op;
                if (funct3 == 3'b001) begin
                    illegal_op = (funct7 != 7'h00);
                end else if (funct3 == 3'b101) begin
                    illegal_op = (funct7 != 7'h00) && (funct7 != 7'h20);
                end
            end
            OPC_LUI: begin
                writes  = 1'b1;
                src_a   = SRC_A_ZERO;
                imm_sel = IMM_U;
            end
            OPC_AUIPC: begin
                writes  = 1'b1;
                src_a   = SRC_A_PC;
                imm_sel = IMM_U;
            end
            OPC_JAL: begin
                writes  = 1'b1;
                jump    = 1'b1;
                src_a   = SRC_A_PC;
                src_b   = SRC_B_FOUR;
                imm_sel = IMM_J;
            end
            OPC_JALR: begin
                writes     = 1'b1;
                jump       = 1'b1;
                jalr       = 1'b1;
                src_a      = SRC_A_PC;
                src_b      = SRC_B_FOUR;
                illegal_op = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                branch  = 1'b1;
                imm_sel = IMM_B;
                case (funct3)
                    3'b000:  cmp_op = CMP_EQ;
                    3'b001:  cmp_op = CMP_NE;
                    3'b100:  cmp_op = CMP_LT;
                    3'b101:  cmp_op = CMP_GE;
                    3'b110:  cmp_op = CMP_LTU;
                    3'b111:  cmp_op = CMP_GEU;
                    default: illegal_op = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                ebreak     = (inst == INST_EBREAK);
                illegal_op = (inst != INST_EBREAK);  // no ecall or csr
            end
            default: illegal_op = 1'b1;
        endcase

        if (illegal_op) begin
            writes = 1'b0;
            branch = 1'b0;
            jump   = 1'b0;
            jalr   = 1'b0;
        end
    end

    assign reg_wen = writes && (rd != '0);

endmodule

`default_nettype wire

// File: hw/rvseed_fetch.sv
// rvseed_fetch: pc register, next-pc mux, Wishbone read FSM, instruction register, halt state
`default_nettype none

module rvseed_fetch #(
    parameter logic [rvseed_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [rvseed_pkg::XLEN-1:0] ibus_dat,
    input  logic                        ibus_ack,
    input  logic                        branch,
    input  logic                        jump,
    input  logic                        jalr,
    input  logic                        cond_true,
    input  logic [rvseed_pkg::XLEN-1:0] imm,
    input  logic [rvseed_pkg::XLEN-1:0] rs1_data,
    input  logic                        ebreak,
    input  logic                        illegal_op,
    output logic [rvseed_pkg::XLEN-1:0] ibus_adr,
    output logic                        ibus_cyc,
    output logic                        ibus_stb,
    output logic [rvseed_pkg::ILEN-1:0] inst,
    output logic [rvseed_pkg::XLEN-1:0] pc,
    output logic                        exec,
    output logic                        commit_valid,
    output logic                        halted,
    output logic                        illegal
);
    import rvseed_pkg::*;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_STOP
    } state_e;

    state_e          state;
    logic            req;       // cyc and stb
    logic            stop;
    logic [XLEN-1:0] jalr_tgt;
    logic [XLEN-1:0] next_pc;

    assign stop     = ebreak | illegal_op;
    assign jalr_tgt = rs1_data + imm;

    always_comb begin
        next_pc = pc + XLEN'(4);
        if (jalr) begin
            next_pc = {jalr_tgt[XLEN-1:1], 1'b0};  // bit 0 cleared
        end else if (jump || (branch && cond_true)) begin
            next_pc = pc + imm;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_FETCH;
            req     <= 1'b0;
            pc      <= RESET_PC;
            halted  <= 1'b0;
            illegal <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!req) begin
                        req <= 1'b1;      // first request out of reset
                    end else if (ibus_ack) begin
                        req   <= 1'b0;
                        state <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    pc <= next_pc;
                    if (stop) begin
                        state   <= ST_STOP;
                        halted  <= 1'b1;
                        illegal <= illegal_op;
                    end else begin
                        req   <= 1'b1;    // next fetch right after exec
                        state <= ST_FETCH;
                    end
                end
                default: begin
                    req <= 1'b0;          // parked until reset
                end
            endcase
        end
    end

    // data is captured in the same cycle that ack is seen
    always_ff @(posedge clk) begin
        if (req && ibus_ack) begin
            inst <= ibus_dat;
        end
    end

    assign ibus_adr     = pc;
    assign ibus_cyc     = req;
    assign ibus_stb     = req;
    assign exec         = (state == ST_EXEC);
    assign commit_valid = exec & ~stop;

endmodule

`default_nettype wire

// File: hw/rvseed_pkg.sv
// core widths, major opcodes and the control enumerations shared by the rvseed RTL
`default_nettype none

package rvseed_pkg;

    localparam int XLEN       = 32;  // data and address width
    localparam int ILEN       = 32;  // instruction width
    localparam int REG_ADDR_W = 5;

    // major opcodes, inst[6:0]
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    localparam logic [ILEN-1:0] INST_EBREAK = 32'h0010_0073;  // only SYSTEM encoding taken

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    // branch compare, rs1 against rs2
    typedef enum logic [2:0] {
        CMP_EQ,
        CMP_NE,
        CMP_LT,
        CMP_GE,
        CMP_LTU,
        CMP_GEU
    } cmp_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_sel_e;

    typedef enum logic [1:0] {
        SRC_A_RS1,
        SRC_A_PC,
        SRC_A_ZERO   // lui
    } src_a_e;

    typedef enum logic [1:0] {
        SRC_B_RS2,
        SRC_B_IMM,
        SRC_B_FOUR   // link address for jal and jalr
    } src_b_e;

endpackage

`default_nettype wire
